//--- sim.f
logic/exec_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/booth_multiplier.sv
logic/exec_control.sv
logic/exec_core.sv
sim/exec_core_tb.sv

//--- sim/exec_core_tb.sv
// Testbench for the execute core
// Random program from a fixed seed, checked against a register-level model
// Every writeback is compared in order, busy is checked every cycle
module exec_core_tb;
   timeunit 1ns;
   timeprecision 100ps;

   // -------------------------------------------------------------------
   // Run length and limits
   // -------------------------------------------------------------------
   localparam int N_INSTR    = 400;
   localparam int RST_CYCLES = 16;
   localparam int CLK_PERIOD = 20;
   // Multiply plus one gap stays below 12 cycles
   localparam int WATCHDOG_CYCLES = N_INSTR * 12 + RST_CYCLES + 20;

   logic                        clk;
   logic                        rst_n;
   logic                        instr_valid;
   logic [exec_pkg::DATA_W-1:0] instr;
   logic                        busy;
   logic                        wb_valid;
   logic [exec_pkg::REG_AW-1:0] wb_rd;
   logic [exec_pkg::DATA_W-1:0] wb_data;

   integer seed = 71;

   // Architectural registers, updated at acceptance
   logic [exec_pkg::DATA_W-1:0] model_regs [exec_pkg::NUM_REGS];

   // Expected writebacks in order, with the cycle they must show up
   int                          exp_due  [$];
   logic [exec_pkg::REG_AW-1:0] exp_rd   [$];
   logic [exec_pkg::DATA_W-1:0] exp_data [$];

   // Fixed opening of the program
   logic [exec_pkg::DATA_W-1:0] directed [$];

   int cyc;
   int busy_last;
   int issued;
   bit accepted;

   exec_core uut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .busy        (busy),
      .wb_valid    (wb_valid),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   // -------------------------------------------------------------------
   // Helpers
   // -------------------------------------------------------------------
   task automatic check(input string name, input logic [15:0] actual,
                        input logic [15:0] expected);
      if (actual !== expected)
      begin
         $display("FAIL %s: got 0x%h, expected 0x%h at cycle %0d",
                  name, actual, expected, cyc);
         $display("RESULT: FAIL");
         $fatal(1);
      end
   endtask

   // Register form word
   function automatic exec_pkg::instr_t make_r(input logic [2:0] op, input logic [2:0] rd,
                                               input logic [2:0] rs1, input logic [2:0] rs2);
      exec_pkg::instr_t w;
      w = '0;
      w.r_form.opcode = op;
      w.r_form.rd     = rd;
      w.r_form.rs1    = rs1;
      w.r_form.rs2    = rs2;
      return w;
   endfunction

   // Load immediate word
   function automatic exec_pkg::instr_t make_li(input logic [2:0] rd, input logic [9:0] imm);
      exec_pkg::instr_t w;
      w = '0;
      w.i_form.opcode = exec_pkg::OP_LI;
      w.i_form.rd     = rd;
      w.i_form.imm    = imm;
      return w;
   endfunction

   // Expected result from the current model registers
   function automatic logic [15:0] model_result(input exec_pkg::instr_t w);
      logic [15:0]        a;
      logic [15:0]        b;
      logic signed [31:0] prod;
      a = model_regs[w.r_form.rs1];
      b = model_regs[w.r_form.rs2];
      case (w.r_form.opcode)
         exec_pkg::OP_ADD: return a + b;
         exec_pkg::OP_SUB: return a - b;
         exec_pkg::OP_AND: return a & b;
         exec_pkg::OP_OR:  return a | b;
         exec_pkg::OP_XOR: return a ^ b;
         exec_pkg::OP_SHL: return a << b[3:0];
         exec_pkg::OP_LI:  return {{6{w.i_form.imm[9]}}, w.i_form.imm};
         default:
         begin
            // Signed product, low half kept
            prod = $signed(a) * $signed(b);
            return prod[15:0];
         end
      endcase
   endfunction

   // -------------------------------------------------------------------
   // One clock cycle, seen from the falling edge
   // -------------------------------------------------------------------
   task automatic step_cycle(output bit took);
      exec_pkg::instr_t w;
      logic [15:0]      result;
      bit               expect_wb;
      @(negedge clk);
      cyc++;
      // Accepted on the edge just passed if busy was low before it
      took = instr_valid && (cyc - 1 > busy_last);
      if (took)
      begin
         w      = instr;
         result = model_result(w);
         model_regs[w.r_form.rd] = result;
         exp_rd.push_back(w.r_form.rd);
         exp_data.push_back(result);
         if (w.r_form.opcode == exec_pkg::OP_MUL)
         begin
            // Done 9 cycles after acceptance, busy until then
            exp_due.push_back(cyc + 8);
            busy_last = cyc + 8;
         end
         else
         begin
            exp_due.push_back(cyc);
         end
      end
      check("busy", busy, cyc <= busy_last);
      expect_wb = (exp_due.size() > 0) && (exp_due[0] == cyc);
      check("wb_valid", wb_valid, expect_wb);
      if (expect_wb)
      begin
         check("wb_rd", wb_rd, exp_rd[0]);
         check("wb_data", wb_data, exp_data[0]);
         void'(exp_due.pop_front());
         void'(exp_rd.pop_front());
         void'(exp_data.pop_front());
      end
   endtask

   // Next word on the falling edge, or a one-cycle gap
   task automatic drive_next();
      logic [31:0] r;
      if (issued >= N_INSTR)
      begin
         instr_valid = 1'b0;
      end
      else if (directed.size() > 0)
      begin
         instr       = directed.pop_front();
         instr_valid = 1'b1;
         issued++;
      end
      else
      begin
         r = $random(seed);
         // Never two gaps in a row
         if (instr_valid && (r[18:16] == 3'd0))
         begin
            instr_valid = 1'b0;
         end
         else
         begin
            // Any 16-bit word decodes to a legal op
            instr       = r[15:0];
            instr_valid = 1'b1;
            issued++;
         end
      end
   endtask

   // -------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------
   initial
   begin
      logic [31:0] r;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      cyc         = 0;
      busy_last   = -1;
      issued      = 0;
      for (int i = 0; i < exec_pkg::NUM_REGS; i++)
      begin
         model_regs[i] = '0;
      end

      // Read back an untouched register through r0
      directed.push_back(make_r(exec_pkg::OP_ADD, 3'd1, 3'd0, 3'd5));
      // Seed all registers
      for (int i = 0; i < exec_pkg::NUM_REGS; i++)
      begin
         r = $random(seed);
         directed.push_back(make_li(i[2:0], r[9:0]));
      end
      // 0x8000 and 0x7FFF built through dependent ops
      directed.push_back(make_li(3'd1, 10'd1));
      directed.push_back(make_li(3'd2, 10'd15));
      directed.push_back(make_r(exec_pkg::OP_SHL, 3'd3, 3'd1, 3'd2));
      directed.push_back(make_r(exec_pkg::OP_SUB, 3'd4, 3'd3, 3'd1));
      // Extreme multiplies, each held behind the one before
      directed.push_back(make_r(exec_pkg::OP_MUL, 3'd5, 3'd3, 3'd4));
      directed.push_back(make_r(exec_pkg::OP_MUL, 3'd6, 3'd3, 3'd3));
      directed.push_back(make_r(exec_pkg::OP_MUL, 3'd7, 3'd4, 3'd4));
      directed.push_back(make_r(exec_pkg::OP_ADD, 3'd0, 3'd5, 3'd7));

      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check("busy", busy, 1'b0);
      check("wb_valid", wb_valid, 1'b0);

      drive_next();
      while ((issued < N_INSTR) || instr_valid || (exp_due.size() > 0))
      begin
         step_cycle(accepted);
         if (accepted || !instr_valid)
            drive_next();
      end

      // Quiet tail, nothing more may be written back
      repeat (4) step_cycle(accepted);

      $display("RESULT: PASS");
      $finish;
   end

   // -------------------------------------------------------------------
   // Watchdog
   // -------------------------------------------------------------------
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the program did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1);
   end

endmodule

//--- logic/exec_core.sv
// Execute core top level
// Register file, ALU, Booth multiplier and control tied together
module exec_core (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          instr_valid,
   input  logic [exec_pkg::DATA_W-1:0]   instr,
   output logic                          busy,
   output logic                          wb_valid,
   output logic [exec_pkg::REG_AW-1:0]   wb_rd,
   output logic [exec_pkg::DATA_W-1:0]   wb_data
);

   // Register read path
   logic [exec_pkg::REG_AW-1:0] rs1_addr;
   logic [exec_pkg::REG_AW-1:0] rs2_addr;
   logic [exec_pkg::DATA_W-1:0] rs1_data;
   logic [exec_pkg::DATA_W-1:0] rs2_data;

   // ALU controls and result
   logic [exec_pkg::OPC_W-1:0]  alu_op;
   logic [exec_pkg::IMM_W-1:0]  alu_imm;
   logic [exec_pkg::DATA_W-1:0] alu_result;

   // Multiplier handshake
   logic                        mul_start;
   logic                        mul_done;
   logic [exec_pkg::DATA_W-1:0] mul_product;

   // -------------------------------------------------------------------
   // Instances
   // -------------------------------------------------------------------
   // Writeback also feeds the register write port
   reg_file u_reg_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_addr_a (rs1_addr),
      .rd_addr_b (rs2_addr),
      .rd_data_a (rs1_data),
      .rd_data_b (rs2_data),
      .wr_en     (wb_valid),
      .wr_addr   (wb_rd),
      .wr_data   (wb_data)
   );

   alu u_alu (
      .op     (alu_op),
      .a      (rs1_data),
      .b      (rs2_data),
      .imm    (alu_imm),
      .result (alu_result)
   );

   // rs1 is the multiplicand, rs2 the multiplier
   booth_multiplier u_booth_multiplier (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (mul_start),
      .multiplicand (rs1_data),
      .multiplier   (rs2_data),
      .product      (mul_product),
      .done         (mul_done)
   );

   exec_control u_exec_control (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .busy        (busy),
      .rs1_addr    (rs1_addr),
      .rs2_addr    (rs2_addr),
      .alu_op      (alu_op),
      .alu_imm     (alu_imm),
      .alu_result  (alu_result),
      .mul_start   (mul_start),
      .mul_done    (mul_done),
      .mul_product (mul_product),
      .wb_valid    (wb_valid),
      .wb_rd       (wb_rd),
      .wb_data     (wb_data)
   );

endmodule

//--- logic/exec_control.sv
// Execute core control
// Decodes the instruction word, accepts when not busy, starts multiplies
// and drives the single writeback port
module exec_control (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          instr_valid,
   input  exec_pkg::instr_t              instr,
   output logic                          busy,
   output logic [exec_pkg::REG_AW-1:0]   rs1_addr,
   output logic [exec_pkg::REG_AW-1:0]   rs2_addr,
   output logic [exec_pkg::OPC_W-1:0]    alu_op,
   output logic [exec_pkg::IMM_W-1:0]    alu_imm,
   input  logic [exec_pkg::DATA_W-1:0]   alu_result,
   output logic                          mul_start,
   input  logic                          mul_done,
   input  logic [exec_pkg::DATA_W-1:0]   mul_product,
   output logic                          wb_valid,
   output logic [exec_pkg::REG_AW-1:0]   wb_rd,
   output logic [exec_pkg::DATA_W-1:0]   wb_data
);

   // Decoded fields
   logic [exec_pkg::OPC_W-1:0]  opcode;
   logic [exec_pkg::REG_AW-1:0] dest;
   logic                        is_mul;
   logic                        accept;

   // Busy flag and pending multiply destination
   logic                        busy_q;
   logic [exec_pkg::REG_AW-1:0] mul_rd_q;

   // ALU writeback stage
   logic                        alu_wb_valid_q;
   logic [exec_pkg::REG_AW-1:0] alu_wb_rd_q;
   logic [exec_pkg::DATA_W-1:0] alu_wb_data_q;

   // -------------------------------------------------------------------
   // Decode
   // -------------------------------------------------------------------
   // Opcode and rd sit in the same place in both forms
   assign opcode   = instr.r_form.opcode;
   assign dest     = instr.r_form.rd;
   assign rs1_addr = instr.r_form.rs1;
   assign rs2_addr = instr.r_form.rs2;

   // Immediate view of the same word
   assign alu_imm  = instr.i_form.imm;
   assign alu_op   = opcode;

   assign is_mul   = (opcode == exec_pkg::OP_MUL);
   assign accept   = instr_valid && !busy_q;

   // One-cycle launch in the accepting cycle
   assign mul_start = accept && is_mul;
   assign busy      = busy_q;

   // -------------------------------------------------------------------
   // Busy tracking
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         busy_q <= 1'b0;
      else if (mul_start)
         busy_q <= 1'b1;
      else if (mul_done)
         busy_q <= 1'b0;
   end

   // Destination held until the product returns
   always_ff @(posedge clk)
   begin
      if (mul_start)
         mul_rd_q <= dest;
   end

   // -------------------------------------------------------------------
   // ALU writeback stage
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         alu_wb_valid_q <= 1'b0;
      else
         alu_wb_valid_q <= accept && !is_mul;
   end

   always_ff @(posedge clk)
   begin
      if (accept && !is_mul)
      begin
         alu_wb_rd_q   <= dest;
         alu_wb_data_q <= alu_result;
      end
   end

   // -------------------------------------------------------------------
   // Writeback select
   // -------------------------------------------------------------------
   // The two sources never fire in the same cycle
   assign wb_valid = alu_wb_valid_q || mul_done;
   assign wb_rd    = mul_done ? mul_rd_q : alu_wb_rd_q;
   assign wb_data  = mul_done ? mul_product : alu_wb_data_q;

endmodule

//--- logic/booth_multiplier.sv
// Radix-4 Booth multiplier
// Two-state FSM, eight add/shift steps, low 16 product bits out
// done pulses for one cycle with the product valid alongside
module booth_multiplier (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start,
   input  logic [exec_pkg::DATA_W-1:0]   multiplicand,
   input  logic [exec_pkg::DATA_W-1:0]   multiplier,
   output logic [exec_pkg::DATA_W-1:0]   product,
   output logic                          done
);

   // FSM state, 0 idle, 1 running
   logic state;
   logic next_state;

   // Step counter
   logic [exec_pkg::CNT_W-1:0] step_cnt;

   // Upper partial, multiplier bits, guard bit
   logic [2*exec_pkg::DATA_W:0] prod_q;

   // Multiplicand and twice the multiplicand
   logic [exec_pkg::DATA_W-1:0] mcand_q;
   logic [exec_pkg::DATA_W-1:0] mcand2_q;

   // Adder output for one step
   logic [exec_pkg::DATA_W-1:0] sum;
   logic [exec_pkg::DATA_W-1:0] upper;

   assign done  = state && (step_cnt == exec_pkg::MUL_STEPS);
   assign upper = prod_q[2*exec_pkg::DATA_W:exec_pkg::DATA_W+1];

   // -------------------------------------------------------------------
   // FSM
   // -------------------------------------------------------------------
   always_comb
   begin
      next_state = state;
      case (state)
         1'b0:
         begin
            if (start)
               next_state = 1'b1;
         end
         default:
         begin
            // Back to idle in the done cycle
            if (done)
               next_state = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= 1'b0;
      else
         state <= next_state;
   end

   // Held at zero while idle, counts every running cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         step_cnt <= '0;
      else if (!state)
         step_cnt <= '0;
      else
         step_cnt <= step_cnt + 1'b1;
   end

   // -------------------------------------------------------------------
   // Booth recode and add
   // -------------------------------------------------------------------
   always_comb
   begin
      case (prod_q[2:0])
         3'b001, 3'b010: sum = upper + mcand_q;
         3'b011:         sum = upper + mcand2_q;
         3'b100:         sum = upper - mcand2_q;
         3'b101, 3'b110: sum = upper - mcand_q;
         // 000 and 111 add nothing
         default:        sum = upper;
      endcase
   end

   // -------------------------------------------------------------------
   // Product register
   // -------------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (!state)
      begin
         // Idle, keep tracking the operands
         prod_q   <= {{exec_pkg::DATA_W{1'b0}}, multiplier, 1'b0};
         mcand_q  <= multiplicand;
         mcand2_q <= {multiplicand[exec_pkg::DATA_W-2:0], 1'b0};
      end
      else if (!done)
      begin
         // Arithmetic shift right by two
         prod_q <= {sum[exec_pkg::DATA_W-1], sum[exec_pkg::DATA_W-1], sum,
                    prod_q[exec_pkg::DATA_W:2]};
      end
   end

   // Low half, above the guard bit
   assign product = prod_q[exec_pkg::DATA_W:1];

endmodule

//--- logic/alu.sv
// Single-cycle ALU
// Add, sub, logic ops, left shift and load immediate
module alu (
   input  logic [exec_pkg::OPC_W-1:0]   op,
   input  logic [exec_pkg::DATA_W-1:0]  a,
   input  logic [exec_pkg::DATA_W-1:0]  b,
   input  logic [exec_pkg::IMM_W-1:0]   imm,
   output logic [exec_pkg::DATA_W-1:0]  result
);

   // Sign-extended immediate
   logic [exec_pkg::DATA_W-1:0] imm_ext;

   // Shift amount, low 4 bits of b only
   logic [3:0] shamt;

   assign imm_ext = {{(exec_pkg::DATA_W - exec_pkg::IMM_W){imm[exec_pkg::IMM_W-1]}}, imm};
   assign shamt   = b[3:0];

   // -------------------------------------------------------------------
   // Operation select
   // -------------------------------------------------------------------
   always_comb
   begin
      case (op)
         exec_pkg::OP_ADD:
         begin
            result = a + b;
         end
         exec_pkg::OP_SUB:
         begin
            result = a - b;
         end
         exec_pkg::OP_AND:
         begin
            result = a & b;
         end
         exec_pkg::OP_OR:
         begin
            result = a | b;
         end
         exec_pkg::OP_XOR:
         begin
            result = a ^ b;
         end
         exec_pkg::OP_SHL:
         begin
            // Logical shift, zeros in from the right
            result = a << shamt;
         end
         exec_pkg::OP_LI:
         begin
            result = imm_ext;
         end
         default:
         begin
            // Multiply goes through the Booth unit, nothing here
            result = '0;
         end
      endcase
   end

endmodule

//--- logic/reg_file.sv
// Register file for the execute core
// Eight 16-bit registers, two async read ports, one write port
// Same-cycle write data is forwarded onto the read ports
module reg_file (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [exec_pkg::REG_AW-1:0]   rd_addr_a,
   input  logic [exec_pkg::REG_AW-1:0]   rd_addr_b,
   output logic [exec_pkg::DATA_W-1:0]   rd_data_a,
   output logic [exec_pkg::DATA_W-1:0]   rd_data_b,
   input  logic                          wr_en,
   input  logic [exec_pkg::REG_AW-1:0]   wr_addr,
   input  logic [exec_pkg::DATA_W-1:0]   wr_data
);

   // Register storage
   logic [exec_pkg::DATA_W-1:0] regs [exec_pkg::NUM_REGS];

   // -------------------------------------------------------------------
   // Write port
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // All registers start at zero
         for (int i = 0; i < exec_pkg::NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr_en)
      begin
         regs[wr_addr] <= wr_data;
      end
   end

   // -------------------------------------------------------------------
   // Read ports with write-through bypass
   // -------------------------------------------------------------------
   always_comb
   begin
      // Port A
      if (wr_en && (wr_addr == rd_addr_a))
         rd_data_a = wr_data;
      else
         rd_data_a = regs[rd_addr_a];

      // Port B
      if (wr_en && (wr_addr == rd_addr_b))
         rd_data_b = wr_data;
      else
         rd_data_b = regs[rd_addr_b];
   end

endmodule

//--- logic/exec_pkg.sv
// Execute core shared definitions
// Widths, opcodes and the instruction word layout
package exec_pkg;

   // -------------------------------------------------------------------
   // Widths
   // -------------------------------------------------------------------
   localparam int DATA_W    = 16;
   localparam int REG_AW    = 3;
   localparam int NUM_REGS  = 8;
   localparam int OPC_W     = 3;
   localparam int IMM_W     = 10;

   // Booth steps, two multiplier bits each
   localparam int MUL_STEPS = 8;
   // Step counter must be able to hold MUL_STEPS itself
   localparam int CNT_W     = $clog2(MUL_STEPS + 1);

   // -------------------------------------------------------------------
   // Opcodes
   // -------------------------------------------------------------------
   localparam logic [OPC_W-1:0] OP_ADD = 3'd0;
   localparam logic [OPC_W-1:0] OP_SUB = 3'd1;
   localparam logic [OPC_W-1:0] OP_AND = 3'd2;
   localparam logic [OPC_W-1:0] OP_OR  = 3'd3;
   localparam logic [OPC_W-1:0] OP_XOR = 3'd4;
   localparam logic [OPC_W-1:0] OP_SHL = 3'd5;
   localparam logic [OPC_W-1:0] OP_LI  = 3'd6;
   localparam logic [OPC_W-1:0] OP_MUL = 3'd7;

   // -------------------------------------------------------------------
   // Instruction word, same 16 bits seen two ways
   // -------------------------------------------------------------------
   typedef union packed {
      struct packed {
         logic [OPC_W-1:0]  opcode;
         logic [REG_AW-1:0] rd;
         logic [REG_AW-1:0] rs1;
         logic [REG_AW-1:0] rs2;
         logic [3:0]        unused;
      } r_form;
      struct packed {
         logic [OPC_W-1:0]  opcode;
         logic [REG_AW-1:0] rd;
         logic [IMM_W-1:0]  imm;
      } i_form;
   } instr_t;

endpackage
